/* Makefile */
SIM       = verilator
TOP       = ethernet_receive_tb
FILE_LIST = src.f
FLAGS     = --binary --timing --assert -j 0
BUILD_DIR = obj_dir
BIN       = $(BUILD_DIR)/V$(TOP)
LOG       = sim.log
SOURCES   = $(shell cat $(FILE_LIST))

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILE_LIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILE_LIST)

run: $(BIN)
	./$(BIN) 2>&1 | tee $(LOG)
	@if grep -q "Done: errors found" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "Done: no errors" $(LOG) || (echo "Simulation did not complete"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* common/eth_rx_pkg.sv */
package eth_rx_pkg;

    typedef logic [7:0]  byte_t;
    typedef logic [31:0] crc_t;
    typedef logic [15:0] count_t;

    typedef struct packed {
        logic  boundary;
        byte_t data;
    } rx_symbol_t;

    typedef struct packed {
        logic  last;
        byte_t data;
    } out_symbol_t;

    typedef enum logic [1:0] {
        SPEED_10M  = 2'd0,
        SPEED_100M = 2'd1,
        SPEED_1G   = 2'd2
    } speed_code_t;

    // Receive slots
    localparam int NUM_SLOTS        = 2;
    localparam int SLOT_INDEX_WIDTH = (NUM_SLOTS > 1) ? $clog2(NUM_SLOTS) : 1;
    localparam int SLOT_DEPTH       = 64;
    // Room for the FCS bytes, stripped on commit
    localparam int SLOT_MEM_DEPTH   = SLOT_DEPTH + 4;
    localparam int SLOT_ADDR_WIDTH  = $clog2(SLOT_MEM_DEPTH + 1);

    typedef logic [NUM_SLOTS-1:0]        slot_mask_t;
    typedef logic [SLOT_INDEX_WIDTH-1:0] slot_index_t;
    typedef logic [SLOT_ADDR_WIDTH-1:0]  slot_addr_t;

    // Idle cycles inside a frame before it is cut off
    localparam int TIMEOUT_10M   = 40;
    localparam int TIMEOUT_100M  = 4;
    localparam int TIMEOUT_1G    = 1;
    localparam int TIMEOUT_WIDTH = $clog2(TIMEOUT_10M + 1);

    typedef logic [TIMEOUT_WIDTH-1:0] idle_count_t;

    // 04C11DB7, bit reversed for the LSB-first update
    localparam crc_t CRC_POLY_REFLECTED = 32'hEDB8_8320;
    localparam crc_t CRC_INIT           = 32'hFFFF_FFFF;

endpackage

/* ethernet_packet_parser/ethernet_packet_parser.sv */
module ethernet_packet_parser import eth_rx_pkg::*; (
    input  logic        clock,
    input  logic        reset_n,
    input  rx_symbol_t  rx_symbol,
    input  logic        rx_valid,
    output logic        rx_ready,
    input  speed_code_t speed_code,
    input  slot_mask_t  slot_free,
    output byte_t       slot_data,
    output slot_mask_t  slot_write,
    output slot_mask_t  frame_good,
    output slot_mask_t  frame_bad,
    output byte_t       crc_data,
    output logic        crc_data_valid,
    output logic        crc_data_last,
    input  crc_t        crc_result,
    input  logic        crc_result_valid,
    output logic        good_pulse,
    output logic        bad_pulse,
    output logic        frame_dropped
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_PARSE,
        S_CHECK,
        S_DROP,
        S_RESTART
    } parser_state_t;

    parser_state_t state;
    slot_index_t   slot_sel;
    slot_index_t   free_slot;
    idle_count_t   idle_count;
    idle_count_t   idle_limit;
    logic [2:0]    fill_count;
    logic          timed_out;
    logic          accepting;
    logic          accept;

    // Last four bytes seen; holds the FCS once the frame has ended
    byte_t [3:0]   fcs_line;

    //////////////////////////////
    // Handshake and timeout
    //////////////////////////////

    always_comb begin
        case (speed_code)
            SPEED_10M:  idle_limit = idle_count_t'(TIMEOUT_10M);
            SPEED_100M: idle_limit = idle_count_t'(TIMEOUT_100M);
            default:    idle_limit = idle_count_t'(TIMEOUT_1G);
        endcase
    end

    assign timed_out = (state == S_PARSE) && (idle_count >= idle_limit);

    always_comb begin
        case (state)
            S_IDLE,
            S_DROP:  accepting = 1'b1;
            S_PARSE: accepting = !timed_out;
            default: accepting = 1'b0;
        endcase
    end

    assign rx_ready = rx_valid && accepting;
    assign accept   = rx_ready;

    // Highest-numbered free slot wins
    always_comb begin
        free_slot = '0;
        for (int k = 0; k < NUM_SLOTS; k++) begin
            if (slot_free[k]) begin
                free_slot = slot_index_t'(k);
            end
        end
    end

    // Oldest byte goes to the CRC once four newer ones are held back
    assign crc_data       = fcs_line[3];
    assign crc_data_valid = accept && (state == S_PARSE) && (fill_count == 3'd4);

    assign good_pulse = |frame_good;
    assign bad_pulse  = |frame_bad;

    always_ff @(posedge clock) begin
        if (accept) begin
            fcs_line  <= {fcs_line[2:0], rx_symbol.data};
            slot_data <= rx_symbol.data;
        end
    end

    //////////////////////////////
    // Frame FSM
    //////////////////////////////

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            state         <= S_IDLE;
            slot_sel      <= '0;
            idle_count    <= '0;
            fill_count    <= '0;
            slot_write    <= '0;
            frame_good    <= '0;
            frame_bad     <= '0;
            crc_data_last <= 1'b0;
            frame_dropped <= 1'b0;
        end else begin
            slot_write    <= '0;
            frame_good    <= '0;
            frame_bad     <= '0;
            crc_data_last <= 1'b0;
            frame_dropped <= 1'b0;

            case (state)
                S_IDLE: begin
                    idle_count <= '0;
                    if (accept && rx_symbol.boundary) begin
                        if (|slot_free) begin
                            slot_sel   <= free_slot;
                            slot_write <= slot_mask_t'(1) << free_slot;
                            fill_count <= 3'd1;
                            state      <= S_PARSE;
                        end else begin
                            state <= S_DROP;
                        end
                    end
                end
                S_PARSE: begin
                    if (timed_out) begin
                        crc_data_last <= 1'b1;
                        state         <= S_CHECK;
                    end else if (accept) begin
                        idle_count <= '0;
                        slot_write <= slot_mask_t'(1) << slot_sel;
                        if (fill_count != 3'd4) begin
                            fill_count <= fill_count + 3'd1;
                        end
                        if (rx_symbol.boundary) begin
                            crc_data_last <= 1'b1;
                            state         <= S_CHECK;
                        end
                    end else begin
                        idle_count <= idle_count + 1'b1;
                    end
                end
                S_CHECK: begin
                    // Leave one cycle after the verdict so slot_free has settled
                    if (good_pulse || bad_pulse) begin
                        state <= S_IDLE;
                    end else if (crc_result_valid) begin
                        if (crc_result == crc_t'(fcs_line)) begin
                            frame_good <= slot_mask_t'(1) << slot_sel;
                        end else begin
                            frame_bad <= slot_mask_t'(1) << slot_sel;
                        end
                    end
                end
                S_DROP: begin
                    if (accept && rx_symbol.boundary) begin
                        frame_dropped <= 1'b1;
                        state         <= S_RESTART;
                    end
                end
                S_RESTART: begin
                    state <= S_IDLE;
                end
                default: begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

    // One verdict at a time and only for a slot that holds the frame
    verdict_exclusive: assert property (@(posedge clock) disable iff (!reset_n)
        $onehot0({frame_good, frame_bad}) && (((frame_good | frame_bad) & slot_free) == '0));

endmodule

/* logic/crc32_engine.sv */
module crc32_engine import eth_rx_pkg::*; (
    input  logic  clock,
    input  logic  reset_n,
    input  byte_t crc_data,
    input  logic  crc_data_valid,
    input  logic  crc_data_last,
    output crc_t  crc_result,
    output logic  crc_result_valid
);

    crc_t crc_state;
    crc_t crc_final;

    // One byte, LSB first
    function automatic crc_t crc_update(crc_t crc, byte_t value);
        crc_t next;
        next = crc ^ {24'h0, value};
        for (int b = 0; b < 8; b++) begin
            next = next[0] ? ((next >> 1) ^ CRC_POLY_REFLECTED) : (next >> 1);
        end
        return next;
    endfunction

    assign crc_final = ~crc_state;

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            crc_state        <= CRC_INIT;
            crc_result_valid <= 1'b0;
        end else begin
            crc_result_valid <= crc_data_last;
            if (crc_data_last) begin
                crc_state <= CRC_INIT;
            end else if (crc_data_valid) begin
                crc_state <= crc_update(crc_state, crc_data);
            end
        end
    end

    // Wire order: low byte is sent first and lands in 31:24
    always_ff @(posedge clock) begin
        if (crc_data_last) begin
            crc_result <= {crc_final[7:0], crc_final[15:8], crc_final[23:16], crc_final[31:24]};
        end
    end

    valid_not_with_last: assert property (@(posedge clock) disable iff (!reset_n)
        !(crc_data_valid && crc_data_last));

endmodule

/* logic/ethernet_receive_top.sv */
module ethernet_receive_top import eth_rx_pkg::*; (
    input  logic        clock,
    input  logic        reset_n,
    input  rx_symbol_t  rx_symbol,
    input  logic        rx_valid,
    output logic        rx_ready,
    input  speed_code_t speed_code,
    output out_symbol_t out_symbol [NUM_SLOTS],
    output slot_mask_t  out_valid,
    input  slot_mask_t  out_ready,
    output count_t      good_count,
    output count_t      bad_count,
    output count_t      dropped_count
);

    slot_mask_t slot_free;
    slot_mask_t slot_write;
    slot_mask_t frame_good;
    slot_mask_t frame_bad;
    byte_t      slot_data;
    byte_t      crc_data;
    logic       crc_data_valid;
    logic       crc_data_last;
    crc_t       crc_result;
    logic       crc_result_valid;
    logic       good_pulse;
    logic       bad_pulse;
    logic       frame_dropped;

    ethernet_packet_parser u_parser (
        .clock            (clock),
        .reset_n          (reset_n),
        .rx_symbol        (rx_symbol),
        .rx_valid         (rx_valid),
        .rx_ready         (rx_ready),
        .speed_code       (speed_code),
        .slot_free        (slot_free),
        .slot_data        (slot_data),
        .slot_write       (slot_write),
        .frame_good       (frame_good),
        .frame_bad        (frame_bad),
        .crc_data         (crc_data),
        .crc_data_valid   (crc_data_valid),
        .crc_data_last    (crc_data_last),
        .crc_result       (crc_result),
        .crc_result_valid (crc_result_valid),
        .good_pulse       (good_pulse),
        .bad_pulse        (bad_pulse),
        .frame_dropped    (frame_dropped)
    );

    crc32_engine u_crc (
        .clock            (clock),
        .reset_n          (reset_n),
        .crc_data         (crc_data),
        .crc_data_valid   (crc_data_valid),
        .crc_data_last    (crc_data_last),
        .crc_result       (crc_result),
        .crc_result_valid (crc_result_valid)
    );

    for (genvar k = 0; k < NUM_SLOTS; k++) begin : g_slot
        receive_slot_buffer u_slot (
            .clock      (clock),
            .reset_n    (reset_n),
            .slot_data  (slot_data),
            .write      (slot_write[k]),
            .good       (frame_good[k]),
            .bad        (frame_bad[k]),
            .slot_free  (slot_free[k]),
            .out_symbol (out_symbol[k]),
            .out_valid  (out_valid[k]),
            .out_ready  (out_ready[k])
        );
    end

    receive_statistics u_stats (
        .clock         (clock),
        .reset_n       (reset_n),
        .good_pulse    (good_pulse),
        .bad_pulse     (bad_pulse),
        .frame_dropped (frame_dropped),
        .good_count    (good_count),
        .bad_count     (bad_count),
        .dropped_count (dropped_count)
    );

endmodule

/* logic/receive_slot_buffer.sv */
module receive_slot_buffer import eth_rx_pkg::*; (
    input  logic        clock,
    input  logic        reset_n,
    input  byte_t       slot_data,
    input  logic        write,
    input  logic        good,
    input  logic        bad,
    output logic        slot_free,
    output out_symbol_t out_symbol,
    output logic        out_valid,
    input  logic        out_ready
);

    byte_t      mem [SLOT_MEM_DEPTH];
    slot_addr_t wr_ptr;
    slot_addr_t rd_ptr;
    slot_addr_t frame_len;
    logic       at_last;

    always_ff @(posedge clock) begin
        if (write) begin
            mem[wr_ptr] <= slot_data;
        end
    end

    assign at_last = (rd_ptr == frame_len - slot_addr_t'(1));

    assign out_symbol.data = mem[rd_ptr];
    assign out_symbol.last = at_last;

    //////////////////////////////
    // Fill, commit and drain
    //////////////////////////////

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            frame_len <= '0;
            out_valid <= 1'b0;
            slot_free <= 1'b1;
        end else begin
            if (write) begin
                wr_ptr    <= wr_ptr + 1'b1;
                slot_free <= 1'b0;
            end

            // FCS bytes are in memory but never read back
            if (good) begin
                frame_len <= wr_ptr - slot_addr_t'(4);
                rd_ptr    <= '0;
                out_valid <= 1'b1;
            end

            if (bad) begin
                wr_ptr    <= '0;
                slot_free <= 1'b1;
            end

            if (out_valid && out_ready) begin
                if (at_last) begin
                    out_valid <= 1'b0;
                    wr_ptr    <= '0;
                    slot_free <= 1'b1;
                end else begin
                    rd_ptr <= rd_ptr + 1'b1;
                end
            end
        end
    end

    // Frames longer than SLOT_DEPTH payload bytes are not supported
    no_write_when_full: assert property (@(posedge clock) disable iff (!reset_n)
        write |-> (wr_ptr < SLOT_MEM_DEPTH));

endmodule

/* logic/receive_statistics.sv */
module receive_statistics import eth_rx_pkg::*; (
    input  logic   clock,
    input  logic   reset_n,
    input  logic   good_pulse,
    input  logic   bad_pulse,
    input  logic   frame_dropped,
    output count_t good_count,
    output count_t bad_count,
    output count_t dropped_count
);

    // Sticks at all ones
    function automatic count_t bump(count_t value, logic hit);
        return (hit && (value != '1)) ? count_t'(value + 1'b1) : value;
    endfunction

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            good_count    <= '0;
            bad_count     <= '0;
            dropped_count <= '0;
        end else begin
            good_count    <= bump(good_count, good_pulse);
            bad_count     <= bump(bad_count, bad_pulse);
            dropped_count <= bump(dropped_count, frame_dropped);
        end
    end

endmodule

/* sim/clock_gen.sv */
module clock_gen (
    output logic clock,
    output logic reset_n
);

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    // Released on a falling edge after three rising edges
    initial begin
        reset_n = 1'b0;
        repeat (3) @(negedge clock);
        reset_n = 1'b1;
    end

endmodule

/* sim/ethernet_receive_tb.sv */
module ethernet_receive_tb import eth_rx_pkg::*; ();

    localparam int   WAIT_LIMIT   = 2000;
    localparam int   READY_ALWAYS = 0;
    localparam int   READY_RANDOM = 1;
    localparam int   READY_HOLD   = 2;
    // CRC-32 of the ASCII string 123456789
    localparam crc_t CHECK_VALUE  = 32'hCBF4_3926;

    logic        clock;
    logic        reset_n;
    rx_symbol_t  rx_symbol;
    logic        rx_valid;
    logic        rx_ready;
    speed_code_t speed_code;
    out_symbol_t out_symbol [NUM_SLOTS];
    slot_mask_t  out_valid;
    slot_mask_t  out_ready;
    count_t      good_count;
    count_t      bad_count;
    count_t      dropped_count;

    // Reference model
    out_symbol_t exp_queue [NUM_SLOTS][$];
    out_symbol_t held_symbol [NUM_SLOTS];
    slot_mask_t  held;
    count_t      exp_good;
    count_t      exp_bad;
    count_t      exp_dropped;
    byte_t       frame [$];
    int          ready_mode;
    int          error_count;

    clock_gen u_clock (
        .clock   (clock),
        .reset_n (reset_n)
    );

    ethernet_receive_top uut (
        .clock         (clock),
        .reset_n       (reset_n),
        .rx_symbol     (rx_symbol),
        .rx_valid      (rx_valid),
        .rx_ready      (rx_ready),
        .speed_code    (speed_code),
        .out_symbol    (out_symbol),
        .out_valid     (out_valid),
        .out_ready     (out_ready),
        .good_count    (good_count),
        .bad_count     (bad_count),
        .dropped_count (dropped_count)
    );

    //////////////////////////////
    // Checks
    //////////////////////////////

    task automatic stop_run(input string what);
        error_count++;
        $display("%s", what);
        $display("Done: errors found");
        $fatal(1);
    endtask

    task automatic wait_failed(input string what);
        stop_run($sformatf("Timeout: waited %0d cycles for %s", WAIT_LIMIT, what));
    endtask

    task automatic check_byte(input string name, input byte_t actual, input byte_t expected);
        if (actual !== expected) begin
            stop_run($sformatf("Fail at time %0t: %s is %02h, expected %02h",
                $time, name, actual, expected));
        end
    endtask

    task automatic check_symbol(input string name, input out_symbol_t actual,
                                input out_symbol_t expected);
        if (actual !== expected) begin
            stop_run($sformatf(
                "Fail at time %0t: %s is last=%0b data=%02h, expected last=%0b data=%02h",
                $time, name, actual.last, actual.data, expected.last, expected.data));
        end
    endtask

    task automatic check_count(input string name, input count_t actual, input count_t expected);
        if (actual !== expected) begin
            stop_run($sformatf("Fail at time %0t: %s is %0d, expected %0d",
                $time, name, actual, expected));
        end
    endtask

    //////////////////////////////
    // Model
    //////////////////////////////

    // Reflected CRC-32 taken one bit at a time with the LSB of each byte first
    function automatic crc_t frame_crc(input byte_t data [$], input int len);
        crc_t crc;
        logic feedback;
        crc = 32'hFFFF_FFFF;
        for (int i = 0; i < len; i++) begin
            for (int b = 0; b < 8; b++) begin
                feedback = crc[0] ^ data[i][b];
                crc      = {1'b0, crc[31:1]};
                if (feedback) begin
                    crc = crc ^ 32'hEDB8_8320;
                end
            end
        end
        return ~crc;
    endfunction

    function automatic int busy_slots();
        int total;
        total = 0;
        for (int k = 0; k < NUM_SLOTS; k++) begin
            if (exp_queue[k].size() != 0) begin
                total++;
            end
        end
        return total;
    endfunction

    task automatic build_frame(input int payload_len, input logic corrupt);
        crc_t fcs;
        int   pos;
        frame.delete();
        for (int i = 0; i < payload_len; i++) begin
            frame.push_back(byte_t'($urandom));
        end
        fcs = frame_crc(frame, payload_len);
        // FCS goes out low byte first
        for (int i = 0; i < 4; i++) begin
            frame.push_back(fcs[8*i +: 8]);
        end
        if (corrupt) begin
            pos        = $urandom_range(payload_len + 3, 0);
            frame[pos] = frame[pos] ^ byte_t'($urandom_range(255, 1));
        end
    endtask

    //////////////////////////////
    // Stimulus
    //////////////////////////////

    task automatic send_byte(input byte_t value, input logic boundary);
        int   waited;
        logic accepted;
        waited             = 0;
        accepted           = 1'b0;
        rx_symbol.boundary = boundary;
        rx_symbol.data     = value;
        rx_valid           = 1'b1;
        while (!accepted) begin
            @(posedge clock);
            accepted = rx_ready;
            waited++;
            if (!accepted && waited >= WAIT_LIMIT) begin
                wait_failed("rx_ready on a frame byte");
            end
        end
        @(negedge clock);
        rx_valid = 1'b0;
    endtask

    task automatic wait_for_slots(input int most_busy, input string what);
        int waited;
        waited = 0;
        while (busy_slots() > most_busy) begin
            @(negedge clock);
            waited++;
            if (waited >= WAIT_LIMIT) begin
                wait_failed(what);
            end
        end
    endtask

    // Sends the first sent bytes of frame; without an end marker the idle timeout closes it
    task automatic send_frame(input int sent, input logic with_end, input int gap_max);
        crc_t        fcs;
        out_symbol_t sym;
        logic        good;
        int          slot;
        int          start_sum;
        int          gap;
        int          waited;
        fcs  = frame_crc(frame, sent - 4);
        good = ({frame[sent-1], frame[sent-2], frame[sent-3], frame[sent-4]} == fcs);
        slot = -1;
        for (int k = 0; k < NUM_SLOTS; k++) begin
            if (exp_queue[k].size() == 0) begin
                slot = k;
            end
        end
        if (slot < 0) begin
            exp_dropped++;
        end else if (good) begin
            exp_good++;
            for (int i = 0; i < sent - 4; i++) begin
                sym.last = (i == sent - 5);
                sym.data = frame[i];
                exp_queue[slot].push_back(sym);
            end
        end else begin
            exp_bad++;
        end
        start_sum = int'(good_count) + int'(bad_count) + int'(dropped_count);

        for (int i = 0; i < sent; i++) begin
            if (i > 0) begin
                gap = $urandom_range(gap_max, 0);
                for (int g = 0; g < gap; g++) begin
                    @(negedge clock);
                end
            end
            send_byte(frame[i], (i == 0) || (with_end && (i == sent - 1)));
        end

        // One more byte right at the idle limit lands outside the frame
        if (!with_end) begin
            for (int g = 0; g <= gap_max; g++) begin
                @(negedge clock);
            end
            send_byte(byte_t'($urandom), 1'b0);
        end

        waited = 0;
        while (int'(good_count) + int'(bad_count) + int'(dropped_count) == start_sum) begin
            @(posedge clock);
            waited++;
            if (waited >= WAIT_LIMIT) begin
                wait_failed("a frame verdict in the counters");
            end
        end
        @(negedge clock);
        check_count("good_count", good_count, exp_good);
        check_count("bad_count", bad_count, exp_bad);
        check_count("dropped_count", dropped_count, exp_dropped);
    endtask

    //////////////////////////////
    // Output side
    //////////////////////////////

    initial begin : ready_driver
        slot_mask_t next_ready;
        out_ready = '0;
        forever begin
            @(posedge clock);
            for (int k = 0; k < NUM_SLOTS; k++) begin
                case (ready_mode)
                    READY_ALWAYS: next_ready[k] = 1'b1;
                    READY_RANDOM: next_ready[k] = ($urandom_range(3, 0) != 0);
                    default:      next_ready[k] = 1'b0;
                endcase
            end
            @(negedge clock);
            out_ready = next_ready;
        end
    end

    always @(posedge clock) begin
        for (int k = 0; k < NUM_SLOTS; k++) begin
            if (reset_n && out_valid[k]) begin
                // Stalled symbol must not move
                if (held[k]) begin
                    check_symbol($sformatf("stalled out_symbol[%0d]", k), out_symbol[k],
                        held_symbol[k]);
                end
                if (out_ready[k]) begin
                    if (exp_queue[k].size() == 0) begin
                        stop_run($sformatf("Slot %0d put out a byte with no frame expected", k));
                    end else begin
                        check_symbol($sformatf("out_symbol[%0d]", k), out_symbol[k],
                            exp_queue[k].pop_front());
                    end
                end
                held[k]        = !out_ready[k];
                held_symbol[k] = out_symbol[k];
            end else begin
                held[k] = 1'b0;
            end
        end
    end

    //////////////////////////////
    // Test sequence
    //////////////////////////////

    initial begin
        crc_t   fcs;
        count_t drops_before;
        int     limit;
        int     waited;
        void'($urandom(32'h1884));
        rx_valid    = 1'b0;
        rx_symbol   = '0;
        speed_code  = SPEED_1G;
        ready_mode  = READY_ALWAYS;
        error_count = 0;
        exp_good    = '0;
        exp_bad     = '0;
        exp_dropped = '0;
        held        = '0;

        // Model sanity against the standard check value
        frame.delete();
        for (int i = 0; i < 9; i++) begin
            frame.push_back(byte_t'(8'h31 + i));
        end
        fcs = frame_crc(frame, 9);
        for (int i = 0; i < 4; i++) begin
            check_byte("reference CRC byte", fcs[8*i +: 8], CHECK_VALUE[8*i +: 8]);
        end

        waited = 0;
        while (!reset_n) begin
            @(negedge clock);
            waited++;
            if (waited >= WAIT_LIMIT) begin
                wait_failed("reset release");
            end
        end
        @(negedge clock);
        check_count("good_count", good_count, '0);
        check_count("bad_count", bad_count, '0);
        check_count("dropped_count", dropped_count, '0);
        if (out_valid != '0) begin
            stop_run("out_valid is high right after reset");
        end

        // Good and corrupted frames with random back-pressure
        ready_mode = READY_RANDOM;
        for (int f = 0; f < 40; f++) begin
            build_frame($urandom_range(60, 1), $urandom_range(3, 0) == 0);
            send_frame(frame.size(), 1'b1, 0);
        end

        // Gaps below the limit and then frames cut off by the idle timeout
        for (int s = 0; s < 3; s++) begin
            speed_code = speed_code_t'(s);
            limit = (s == 0) ? TIMEOUT_10M : ((s == 1) ? TIMEOUT_100M : TIMEOUT_1G);
            for (int f = 0; f < 10; f++) begin
                build_frame($urandom_range(60, 1), $urandom_range(3, 0) == 0);
                send_frame(frame.size(), 1'b1, limit - 1);
            end
            for (int f = 0; f < 3; f++) begin
                wait_for_slots(NUM_SLOTS - 1, "a free slot before a truncated frame");
                build_frame($urandom_range(60, 1), 1'b0);
                send_frame((f == 0) ? frame.size() : $urandom_range(frame.size(), 5), 1'b0,
                    limit - 1);
            end
        end

        // Fill both slots so that one frame more is dropped
        speed_code = SPEED_1G;
        ready_mode = READY_ALWAYS;
        wait_for_slots(0, "all slots to drain before the drop test");
        ready_mode = READY_HOLD;
        drops_before = exp_dropped;
        for (int f = 0; f < NUM_SLOTS + 1; f++) begin
            build_frame($urandom_range(60, 1), 1'b0);
            send_frame(frame.size(), 1'b1, 0);
        end
        check_count("dropped_count", dropped_count, drops_before + count_t'(1));

        ready_mode = READY_ALWAYS;
        wait_for_slots(NUM_SLOTS - 1, "a slot to be read out after the drop");
        build_frame($urandom_range(60, 1), 1'b0);
        send_frame(frame.size(), 1'b1, 0);

        ready_mode = READY_RANDOM;
        for (int f = 0; f < 10; f++) begin
            build_frame($urandom_range(60, 1), 1'b0);
            send_frame(frame.size(), 1'b1, 0);
        end

        wait_for_slots(0, "all expected frames to be read out");
        check_count("good_count", good_count, exp_good);
        check_count("bad_count", bad_count, exp_bad);
        check_count("dropped_count", dropped_count, exp_dropped);

        if (error_count == 0) begin
            $display("Done: no errors");
            $finish;
        end else begin
            $display("Done: errors found");
            $fatal(1);
        end
    end

endmodule

/* src.f */
common/eth_rx_pkg.sv
logic/crc32_engine.sv
logic/receive_slot_buffer.sv
logic/receive_statistics.sv
ethernet_packet_parser/ethernet_packet_parser.sv
logic/ethernet_receive_top.sv
sim/clock_gen.sv
sim/ethernet_receive_tb.sv
